/* rtl/cache_pkg.sv */
package cache_pkg;

	localparam int addr_width = 32;
	localparam int line_width = 256;
	localparam int word_width = 32;
	localparam int num_sets = 8;
	localparam int index_width = 3;
	localparam int offset_width = 5;
	localparam int tag_width = addr_width - index_width - offset_width;
	localparam int word_sel_width = 3;
	localparam int byte_sel_width = offset_width - word_sel_width;

	typedef struct packed {
		logic [tag_width-1:0] tag;
		logic [index_width-1:0] index;
		logic [word_sel_width-1:0] word_sel; // word within the line.
		logic [byte_sel_width-1:0] byte_off;
	} addr_fields_t;

	// fetch address seen flat or split into cache fields.
	typedef union packed {
		logic [addr_width-1:0] word;
		addr_fields_t fields;
	} cache_addr_t;

	typedef struct packed {
		logic read;
		logic write;
		logic [addr_width-1:0] addr; // line aligned.
		logic [line_width-1:0] wdata;
	} pmem_req_t;

	typedef struct packed {
		logic resp; // one cycle, ends the transaction.
		logic [line_width-1:0] rdata;
	} pmem_rsp_t;

endpackage

/* rtl/icache_control.sv */
`timescale 1ns/1ps

module icache_control (
	input  logic       clk,
	input  logic       reset,
	input  logic       req_valid,
	input  logic       rsp_ready,
	input  logic       hit,
	input  logic       lru_way,
	input  logic       pmem_resp,
	output logic       req_ready,
	output logic       rsp_valid,
	output logic       pmem_read,
	output logic       load_req,
	output logic [1:0] load_line,
	output logic [1:0] set_valid,
	output logic       load_lru,
	output logic       hold_line,
	output logic       select_held
);

	typedef enum logic [1:0] {
		idle,
		hit_detect,
		refill,
		rsp_hold
	} state_t;

	state_t state;
	state_t next_state;

	always_ff @(posedge clk) begin
		if (reset)
			state <= idle;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		unique case (state)
			idle: if (req_valid)
				next_state = hit_detect;
			hit_detect: begin
				if (!hit)
					next_state = refill;
				else if (!rsp_ready)
					next_state = rsp_hold; // park the hit line.
				else
					next_state = req_valid ? hit_detect : idle;
			end
			refill: if (pmem_resp)
				next_state = rsp_hold;
			rsp_hold: if (rsp_ready)
				next_state = req_valid ? hit_detect : idle;
			default: next_state = idle;
		endcase
	end

	always_comb begin
		req_ready = 1'b0;
		rsp_valid = 1'b0;
		pmem_read = 1'b0;
		load_line = 2'b00;
		set_valid = 2'b00;
		load_lru = 1'b0;
		hold_line = 1'b0;
		select_held = 1'b0;
		unique case (state)
			idle: req_ready = 1'b1;
			hit_detect: begin
				if (hit) begin
					rsp_valid = 1'b1;
					load_lru = 1'b1;
					req_ready = rsp_ready; // next fetch streams in behind this one.
					hold_line = !rsp_ready;
				end else begin
					pmem_read = 1'b1;
				end
			end
			refill: begin
				pmem_read = 1'b1; // held through the resp cycle.
				if (pmem_resp) begin
					load_line[lru_way] = 1'b1;
					set_valid[lru_way] = 1'b1;
					load_lru = 1'b1;
					hold_line = 1'b1;
				end
			end
			rsp_hold: begin
				rsp_valid = 1'b1;
				select_held = 1'b1;
				req_ready = rsp_ready;
			end
			default: req_ready = 1'b0;
		endcase
	end

	assign load_req = req_valid & req_ready;

endmodule

/* rtl/icache_datapath.sv */
`timescale 1ns/1ps

module icache_datapath (
	input  logic                             clk,
	input  logic                             reset,
	input  cache_pkg::cache_addr_t           req_addr,
	input  logic                             load_req,
	input  logic [1:0]                       load_line,
	input  logic [1:0]                       set_valid,
	input  logic                             load_lru,
	input  logic                             hold_line,
	input  logic                             select_held,
	input  logic [cache_pkg::line_width-1:0] pmem_rdata,
	output logic                             hit,
	output logic                             lru_way,
	output logic [cache_pkg::word_width-1:0] rsp_data,
	output logic [cache_pkg::addr_width-1:0] pmem_addr
);
	import cache_pkg::*;

	cache_addr_t addr_q;
	logic [tag_width-1:0] tag_q [2][num_sets];
	logic [line_width-1:0] data_q [2][num_sets];
	logic [num_sets-1:0] valid_q [2];
	logic [num_sets-1:0] lru_q; // way to replace next.
	logic [line_width-1:0] held_q;
	logic [index_width-1:0] idx;
	logic [1:0] way_hit;
	logic [line_width-1:0] hit_line;
	logic [line_width-1:0] out_line;

	assign idx = addr_q.fields.index;

	always_ff @(posedge clk) begin
		if (load_req)
			addr_q <= req_addr;
	end

	always_comb begin
		for (int w = 0; w < 2; w++)
			way_hit[w] = valid_q[w][idx] && (tag_q[w][idx] == addr_q.fields.tag);
	end

	assign hit = |way_hit;
	assign hit_line = way_hit[1] ? data_q[1][idx] : data_q[0][idx];
	assign lru_way = lru_q[idx];

	always_ff @(posedge clk) begin
		for (int w = 0; w < 2; w++) begin
			if (load_line[w]) begin
				tag_q[w][idx] <= addr_q.fields.tag;
				data_q[w][idx] <= pmem_rdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q[0] <= '0;
			valid_q[1] <= '0;
			lru_q <= '0;
		end else begin
			for (int w = 0; w < 2; w++) begin
				if (set_valid[w])
					valid_q[w][idx] <= 1'b1;
			end
			// point away from the way just used.
			if (load_lru)
				lru_q[idx] <= hit ? ~way_hit[1] : ~lru_q[idx];
		end
	end

	// refill data, or the hit line when the consumer stalls.
	always_ff @(posedge clk) begin
		if (hold_line)
			held_q <= hit ? hit_line : pmem_rdata;
	end

	assign out_line = select_held ? held_q : hit_line;
	assign rsp_data = out_line[addr_q.fields.word_sel*word_width +: word_width];
	assign pmem_addr = {addr_q.fields.tag, idx, {offset_width{1'b0}}};

endmodule

/* rtl/icache.sv */
`timescale 1ns/1ps

module icache (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             req_valid,
	input  cache_pkg::cache_addr_t           req_addr,
	output logic                             req_ready,
	output logic                             rsp_valid,
	output logic [cache_pkg::word_width-1:0] rsp_data,
	input  logic                             rsp_ready,
	output cache_pkg::pmem_req_t             ic_req,
	input  cache_pkg::pmem_rsp_t             ic_rsp
);
	import cache_pkg::*;

	logic hit;
	logic lru_way;
	logic pmem_read;
	logic load_req;
	logic [1:0] load_line;
	logic [1:0] set_valid;
	logic load_lru;
	logic hold_line;
	logic select_held;
	logic [addr_width-1:0] pmem_addr;

	icache_control control0 (
		.clk         (clk),
		.reset       (reset),
		.req_valid   (req_valid),
		.rsp_ready   (rsp_ready),
		.hit         (hit),
		.lru_way     (lru_way),
		.pmem_resp   (ic_rsp.resp),
		.req_ready   (req_ready),
		.rsp_valid   (rsp_valid),
		.pmem_read   (pmem_read),
		.load_req    (load_req),
		.load_line   (load_line),
		.set_valid   (set_valid),
		.load_lru    (load_lru),
		.hold_line   (hold_line),
		.select_held (select_held)
	);

	icache_datapath datapath0 (
		.clk         (clk),
		.reset       (reset),
		.req_addr    (req_addr),
		.load_req    (load_req),
		.load_line   (load_line),
		.set_valid   (set_valid),
		.load_lru    (load_lru),
		.hold_line   (hold_line),
		.select_held (select_held),
		.pmem_rdata  (ic_rsp.rdata),
		.hit         (hit),
		.lru_way     (lru_way),
		.rsp_data    (rsp_data),
		.pmem_addr   (pmem_addr)
	);

	// the cache only ever reads.
	always_comb begin
		ic_req.read = pmem_read;
		ic_req.write = 1'b0;
		ic_req.addr = pmem_addr;
		ic_req.wdata = '0;
	end

endmodule

/* rtl/pmem_arbiter.sv */
`timescale 1ns/1ps

module pmem_arbiter (
	input  logic                 clk,
	input  logic                 reset,
	input  cache_pkg::pmem_req_t ic_req,
	output cache_pkg::pmem_rsp_t ic_rsp,
	input  logic                 lp_req_valid,
	input  cache_pkg::pmem_req_t lp_req,
	output cache_pkg::pmem_rsp_t lp_rsp,
	output cache_pkg::pmem_req_t pmem_req,
	input  cache_pkg::pmem_rsp_t pmem_rsp
);
	import cache_pkg::*;

	pmem_req_t lp_q;
	logic busy;
	logic owner; // 1 when the line port holds the bus.
	logic prio; // 1 when the line port wins a tie.
	logic ic_pend;
	logic grant_lp;

	assign ic_pend = ic_req.read | ic_req.write;
	assign grant_lp = lp_req_valid && (!ic_pend || prio);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			owner <= 1'b0;
			prio <= 1'b0;
		end else if (!busy) begin
			if (ic_pend || lp_req_valid) begin
				busy <= 1'b1;
				owner <= grant_lp;
			end
		end else if (pmem_rsp.resp) begin
			busy <= 1'b0;
			prio <= ~owner; // other requester goes first next time.
		end
	end

	// line port may drop its request once granted.
	always_ff @(posedge clk) begin
		if (!busy && grant_lp)
			lp_q <= lp_req;
	end

	always_comb begin
		pmem_req = '0;
		ic_rsp = '0;
		lp_rsp = '0;
		if (busy) begin
			pmem_req = owner ? lp_q : ic_req;
			if (owner)
				lp_rsp = pmem_rsp;
			else
				ic_rsp = pmem_rsp;
		end
	end

endmodule

/* rtl/cache_subsystem.sv */
`timescale 1ns/1ps

module cache_subsystem (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             req_valid,
	input  cache_pkg::cache_addr_t           req_addr,
	output logic                             req_ready,
	output logic                             rsp_valid,
	output logic [cache_pkg::word_width-1:0] rsp_data,
	input  logic                             rsp_ready,
	input  logic                             lp_req_valid,
	input  cache_pkg::pmem_req_t             lp_req,
	output cache_pkg::pmem_rsp_t             lp_rsp,
	output cache_pkg::pmem_req_t             pmem_req,
	input  cache_pkg::pmem_rsp_t             pmem_rsp
);
	import cache_pkg::*;

	pmem_req_t ic_req;
	pmem_rsp_t ic_rsp;

	icache icache0 (
		.clk       (clk),
		.reset     (reset),
		.req_valid (req_valid),
		.req_addr  (req_addr),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data),
		.rsp_ready (rsp_ready),
		.ic_req    (ic_req),
		.ic_rsp    (ic_rsp)
	);

	pmem_arbiter arbiter0 (
		.clk          (clk),
		.reset        (reset),
		.ic_req       (ic_req),
		.ic_rsp       (ic_rsp),
		.lp_req_valid (lp_req_valid),
		.lp_req       (lp_req),
		.lp_rsp       (lp_rsp),
		.pmem_req     (pmem_req),
		.pmem_rsp     (pmem_rsp)
	);

endmodule

/* verification/pmem_model.sv */
`timescale 1ns/1ps

module pmem_model (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [3:0]           latency,
	input  cache_pkg::pmem_req_t pmem_req,
	output cache_pkg::pmem_rsp_t pmem_rsp
);
	import cache_pkg::*;

	logic [line_width-1:0] store [logic [addr_width-1:0]]; // lines written so far.
	logic active;
	logic [3:0] count;

	// unwritten lines hold each word's byte address xor a fixed pattern.
	function automatic logic [line_width-1:0] line_at(input logic [addr_width-1:0] addr);
		logic [line_width-1:0] line;
		if (store.exists(addr))
			return store[addr];
		for (int w = 0; w < 8; w++)
			line[w*word_width +: word_width] = (addr + 4 * w) ^ 32'h5a5a_0000;
		return line;
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			count <= '0;
			pmem_rsp <= '0;
		end else begin
			pmem_rsp <= '0;
			if (active) begin
				if (count <= 1) begin
					active <= 1'b0;
					pmem_rsp.resp <= 1'b1;
					pmem_rsp.rdata <= line_at(pmem_req.addr);
					if (pmem_req.write)
						store[pmem_req.addr] = pmem_req.wdata;
				end else begin
					count <= count - 1;
				end
			end else if ((pmem_req.read || pmem_req.write) && !pmem_rsp.resp) begin
				active <= 1'b1; // request still up in the resp cycle is not new.
				count <= latency;
			end
		end
	end

endmodule

/* verification/tb_cache_subsystem.sv */
`timescale 1ns/1ps

module tb_cache_subsystem;
	import cache_pkg::*;

	localparam int num_tests = 5;
	localparam int clk_period = 40;

	logic clk;
	logic reset;
	logic req_valid;
	cache_addr_t req_addr;
	logic req_ready;
	logic rsp_valid;
	logic [word_width-1:0] rsp_data;
	logic rsp_ready;
	logic lp_req_valid;
	pmem_req_t lp_req;
	pmem_rsp_t lp_rsp;
	pmem_req_t pmem_req;
	pmem_rsp_t pmem_rsp;
	logic [3:0] latency;
	logic [31:0] lfsr = 32'hade8b933;
	int read_count = 0;
	logic [255:0] ref_lines [logic [31:0]]; // lines written through the line port.

	cache_subsystem dut0 (
		.clk          (clk),
		.reset        (reset),
		.req_valid    (req_valid),
		.req_addr     (req_addr),
		.req_ready    (req_ready),
		.rsp_valid    (rsp_valid),
		.rsp_data     (rsp_data),
		.rsp_ready    (rsp_ready),
		.lp_req_valid (lp_req_valid),
		.lp_req       (lp_req),
		.lp_rsp       (lp_rsp),
		.pmem_req     (pmem_req),
		.pmem_rsp     (pmem_rsp)
	);

	pmem_model mem0 (
		.clk      (clk),
		.reset    (reset),
		.latency  (latency),
		.pmem_req (pmem_req),
		.pmem_rsp (pmem_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(negedge clk) begin
		if (pmem_rsp.resp && pmem_req.read)
			read_count++;
	end

	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] val;
		logic b;
		val = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr[0];
			lfsr = lfsr >> 1;
			if (b)
				lfsr = lfsr ^ 32'h8020_0003;
			val = {val[30:0], b};
		end
		return val;
	endfunction

	function automatic logic [255:0] ref_line(input logic [31:0] line_addr);
		logic [255:0] line;
		if (ref_lines.exists(line_addr))
			return ref_lines[line_addr];
		for (int w = 0; w < 8; w++)
			line[w*32 +: 32] = (line_addr + 4 * w) ^ 32'h5a5a_0000;
		return line;
	endfunction

	function automatic logic [31:0] ref_word(input logic [31:0] addr);
		logic [255:0] line;
		line = ref_line({addr[31:5], 5'b0});
		return line[addr[4:2]*32 +: 32];
	endfunction

	task automatic expect_equal(input string name, input logic [255:0] expected,
			input logic [255:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "check failed in %s", name);
		end
	endtask

	// one fetch; stall is the number of cycles rsp_ready stays low.
	task automatic fetch(input string name, input logic [31:0] addr, input int exp_reads,
			input int stall);
		int reads0;
		logic [31:0] expected;
		reads0 = read_count;
		expected = ref_word(addr);
		latency = 4'd1 + next_bits(3);
		rsp_ready = (stall == 0);
		req_valid = 1'b1;
		req_addr.word = addr;
		@(negedge clk);
		while (!req_ready)
			@(negedge clk);
		@(posedge clk);
		#2 req_valid = 1'b0;
		@(negedge clk);
		while (!rsp_valid) begin
			expect_equal(name, 0, req_ready); // nothing accepted during a miss.
			@(negedge clk);
		end
		expect_equal(name, expected, rsp_data);
		repeat (stall) begin
			@(negedge clk);
			expect_equal(name, 1, rsp_valid);
			expect_equal(name, expected, rsp_data);
			expect_equal(name, 0, req_ready);
		end
		if (stall > 0) begin
			@(posedge clk);
			#2 rsp_ready = 1'b1;
		end
		@(posedge clk);
		#2;
		expect_equal(name, exp_reads, read_count - reads0);
	endtask

	task automatic line_access(input logic write, input logic [31:0] addr,
			input logic [255:0] wdata, output logic [255:0] rdata);
		lp_req.read = !write;
		lp_req.write = write;
		lp_req.addr = addr;
		lp_req.wdata = wdata;
		lp_req_valid = 1'b1;
		@(negedge clk);
		while (!lp_rsp.resp)
			@(negedge clk);
		rdata = lp_rsp.rdata;
		@(posedge clk);
		#2 lp_req_valid = 1'b0;
		lp_req = '0;
	endtask

	task automatic cold_miss();
		@(negedge clk);
		expect_equal("reset", 0, rsp_valid);
		expect_equal("reset", 0, pmem_req.read | pmem_req.write);
		expect_equal("reset", 0, lp_rsp.resp);
		expect_equal("reset", 1, req_ready);
		@(posedge clk);
		#2;
		fetch("cold miss", 32'h0000_1004, 1, 0);
	endtask

	task automatic hit_reuse();
		logic [31:0] addrs [8];
		int reads0;
		fetch("hit", 32'h0000_1000, 0, 0);
		fetch("hit", 32'h0000_101c, 0, 0);
		reads0 = read_count;
		for (int k = 0; k < 8; k++)
			addrs[k] = 32'h0000_1000 + 4 * next_bits(3);
		rsp_ready = 1'b1;
		req_valid = 1'b1;
		// a response every cycle while the next address is accepted.
		for (int k = 0; k <= 8; k++) begin
			if (k < 8)
				req_addr.word = addrs[k];
			else
				req_valid = 1'b0;
			if (k > 0) begin
				@(negedge clk);
				expect_equal("hit stream", 1, rsp_valid);
				expect_equal("hit stream", 1, req_ready);
				expect_equal("hit stream", ref_word(addrs[k-1]), rsp_data);
			end
			@(posedge clk);
			#2;
		end
		expect_equal("hit stream", 0, read_count - reads0);
	endtask

	task automatic lru_replace();
		fetch("lru fill a", 32'h0000_2040, 1, 0); // all three map to set 2.
		fetch("lru fill b", 32'h0000_3044, 1, 0);
		fetch("lru touch a", 32'h0000_2048, 0, 0);
		fetch("lru fill c", 32'h0000_4040, 1, 0);
		fetch("lru keep a", 32'h0000_205c, 0, 0);
		fetch("lru evict b", 32'h0000_3040, 1, 0);
	endtask

	task automatic back_pressure();
		fetch("stall hit", 32'h0000_1010, 0, 4);
		fetch("stall miss", 32'h0000_6008, 1, 5);
	endtask

	task automatic share_bus();
		logic [255:0] wdata;
		logic [255:0] rdata;
		for (int w = 0; w < 8; w++)
			wdata[w*32 +: 32] = next_bits(32);
		fork
			fetch("shared miss", 32'h0000_5000, 1, 0);
			begin
				@(posedge clk); // lands while the miss is pending.
				#2;
				line_access(1'b1, 32'h0000_8000, wdata, rdata);
			end
		join
		ref_lines[32'h0000_8000] = wdata;
		fetch("written line", 32'h0000_8000 + 4 * next_bits(3), 1, 0);
		line_access(1'b0, 32'h0000_8000, '0, rdata);
		expect_equal("lp read written", ref_line(32'h0000_8000), rdata);
		line_access(1'b0, 32'h0000_9000, '0, rdata);
		expect_equal("lp read", ref_line(32'h0000_9000), rdata);
	endtask

	initial begin
		reset = 1'b1;
		req_valid = 1'b0;
		req_addr = '0;
		rsp_ready = 1'b1;
		lp_req_valid = 1'b0;
		lp_req = '0;
		latency = 4'd1;
		repeat (3) @(posedge clk);
		#2 reset = 1'b0;
		cold_miss();
		hit_reuse();
		lru_replace();
		back_pressure();
		share_bus();
		$display("RESULT: PASS");
		$finish;
	end

	initial begin
		#(num_tests * 2000 * clk_period);
		$display("watchdog expired, the run hung");
		$display("RESULT: FAIL");
		$fatal(1, "timeout");
	end

endmodule

/* filelist.f */
rtl/cache_pkg.sv
rtl/icache_control.sv
rtl/icache_datapath.sv
rtl/icache.sv
rtl/pmem_arbiter.sv
rtl/cache_subsystem.sv
verification/pmem_model.sv
verification/tb_cache_subsystem.sv

/* Bender.yml */
package:
  name: cache_subsystem

sources:
  - rtl/cache_pkg.sv
  - rtl/icache_control.sv
  - rtl/icache_datapath.sv
  - rtl/icache.sv
  - rtl/pmem_arbiter.sv
  - rtl/cache_subsystem.sv
  - target: test
    files:
      - verification/pmem_model.sv
      - verification/tb_cache_subsystem.sv
